// ==== common/spi_settings.svh ====
/* Build-time constants for the SPI host. SPI_DEFAULT_DIV must be non-zero.
   Register offsets are byte offsets from a base of zero. */
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Frame and timing
`define SPI_DATA_WIDTH 8
`define SPI_DEFAULT_DIV 4   // clk cycles per SCLK half-period

// Entries in each of the TX and RX queues
`define SPI_FIFO_DEPTH 4

// AXI4-Lite register map
`define SPI_REG_TXDATA 'h0
`define SPI_REG_RXDATA 'h4
`define SPI_REG_STATUS 'h8
`define SPI_REG_CTRL 'hC

`endif

// ==== common/spi_types_pkg.sv ====
/* Payload and status types of the SPI host. Frame width comes from spi_settings.svh */
`include "spi_settings.svh"

package spi_types_pkg;

    // One queued frame to transmit
    typedef struct packed {
        logic [`SPI_DATA_WIDTH-1:0] data;
    } spi_cmd_t;

    // One frame captured from MISO
    typedef struct packed {
        logic [`SPI_DATA_WIDTH-1:0] data;
    } spi_rx_t;

    // STATUS register layout, busy in bit 3 down to rx_overflow in bit 0
    typedef struct packed {
        logic busy;        // Frame in flight or queued
        logic tx_full;
        logic rx_empty;
        logic rx_overflow; // Sticky until cleared through CTRL
    } spi_status_t;

endpackage

// ==== common/axil_pkg.sv ====
/* AXI4-Lite channel bundles with a 16-bit address and a 32-bit data bus.
   Only OKAY and SLVERR responses are produced. */
package axil_pkg;

    typedef logic [15:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Manager to subordinate
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // Subordinate to manager
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_e bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_e rresp;
    } axil_rsp_t;

endpackage

// ==== verilog/sync_fifo.sv ====
/* Single-clock queue, any payload type. Push when full and pop when empty are ignored.
   pop_data shows the head entry combinationally. */
`timescale 1ns/1ns
`include "spi_settings.svh"

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `SPI_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr, rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 push_ok, pop_ok;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign push_ok  = push && !full;
    assign pop_ok   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    // Pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wr_ptr] <= push_data;
    end

    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        full && push |=> $stable(wr_ptr));

    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        empty && pop |=> $stable(rd_ptr));

endmodule

// ==== verilog/axil_reg_decode.sv ====
/* AXI4-Lite register slave. AW and W must be presented together, one access in flight
   per direction. Writes to read-only registers answer SLVERR. */
`timescale 1ns/1ns
`include "spi_settings.svh"

module axil_reg_decode (
    input  logic                       clk,
    input  logic                       rst,
    input  axil_pkg::axil_req_t        axil_req,
    output axil_pkg::axil_rsp_t        axil_rsp,
    output logic                       tx_push,
    output spi_types_pkg::spi_cmd_t    tx_data,
    input  logic                       tx_full,
    output logic                       rx_pop,
    input  spi_types_pkg::spi_rx_t     rx_data,
    input  logic                       rx_empty,
    input  spi_types_pkg::spi_status_t status,
    output logic [7:0]                 clk_div,
    output logic                       clear_overflow
);
    import axil_pkg::*;

    localparam int W = `SPI_DATA_WIDTH;

    logic       wr_accept, rd_accept;
    logic       wr_is_tx, wr_is_ctrl, rd_is_rx;
    axil_resp_e wr_resp, rd_resp;
    axil_data_t rd_word;
    logic       bvalid_q, rvalid_q;
    axil_resp_e bresp_q, rresp_q;
    axil_data_t rdata_q;

    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_accept = axil_req.arvalid && !rvalid_q;

    // Write address decode
    always_comb begin
        wr_is_tx   = (axil_req.awaddr == `SPI_REG_TXDATA);
        wr_is_ctrl = (axil_req.awaddr == `SPI_REG_CTRL);
        if (wr_is_tx)
            wr_resp = tx_full ? SLVERR : OKAY; // Dropped when queue is full
        else if (wr_is_ctrl)
            wr_resp = OKAY;
        else
            wr_resp = SLVERR;
    end

    // Read address decode and read word assembly
    always_comb begin
        rd_is_rx = (axil_req.araddr == `SPI_REG_RXDATA);
        rd_word  = '0;
        rd_resp  = OKAY;
        if (rd_is_rx) begin
            if (rx_empty)
                rd_resp = SLVERR;              // Zero data on empty queue
            else
                rd_word[W-1:0] = rx_data.data;
        end else if (axil_req.araddr == `SPI_REG_STATUS) begin
            rd_word[$bits(status)-1:0] = status;
        end else if (axil_req.araddr == `SPI_REG_CTRL) begin
            rd_word[7:0] = clk_div;
        end else begin
            rd_resp = SLVERR;
        end
    end

    assign tx_push        = wr_accept && wr_is_tx && !tx_full;
    assign tx_data.data   = axil_req.wdata[W-1:0];
    assign rx_pop         = rd_accept && rd_is_rx && !rx_empty;
    assign clear_overflow = wr_accept && wr_is_ctrl && axil_req.wstrb[1] && axil_req.wdata[8];

    // Handshake state and divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            clk_div  <= 8'(`SPI_DEFAULT_DIV);
        end else begin
            if (wr_accept)
                bvalid_q <= 1'b1;
            else if (axil_req.bready)
                bvalid_q <= 1'b0;
            if (rd_accept)
                rvalid_q <= 1'b1;
            else if (axil_req.rready)
                rvalid_q <= 1'b0;
            if (wr_accept && wr_is_ctrl && axil_req.wstrb[0]) begin
                // Zero would stall the half-period counter
                clk_div <= (axil_req.wdata[7:0] == 8'd0) ? 8'd1 : axil_req.wdata[7:0];
            end
        end
    end

    // Response payload, held while valid is up
    always_ff @(posedge clk) begin
        if (wr_accept)
            bresp_q <= wr_resp;
        if (rd_accept) begin
            rresp_q <= rd_resp;
            rdata_q <= rd_word;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = rd_accept;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

    // Write response must wait for the manager
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid_q && !axil_req.bready |=> bvalid_q);

endmodule

// ==== spi_engine/spi_shift_engine.sv ====
/* SPI mode 0 shift engine, one chip select, MSB first. The divider is sampled when a
   frame starts and must be non-zero. */
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_shift_engine (
    input  logic                    clk,
    input  logic                    rst,
    input  spi_types_pkg::spi_cmd_t cmd,
    input  logic                    cmd_empty,
    output logic                    cmd_pop,
    input  logic [7:0]              clk_div,
    input  logic                    clear_overflow,
    input  logic                    rx_full,
    output logic                    rx_push,
    output spi_types_pkg::spi_rx_t  rx_frame,
    output logic                    busy,
    output logic                    rx_overflow,
    output logic                    sclk,
    output logic                    mosi,
    input  logic                    miso,
    output logic                    cs_n
);
    localparam int W      = `SPI_DATA_WIDTH;
    localparam int EDGE_W = $clog2(2 * W);
    localparam logic [EDGE_W-1:0] LAST_HALF = EDGE_W'(2 * W - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ASSERT,   // First half-period, SCLK low, MOSI set up
        ST_TRANSFER,
        ST_DEASSERT
    } state_t;

    state_t            state;
    logic [7:0]        div_q;
    logic [7:0]        div_cnt;
    logic [EDGE_W-1:0] half_cnt;    // Index of the current half-period
    logic [W-1:0]      tx_shift;
    logic [W-1:0]      rx_shift;
    logic              half_end;
    logic              rise_evt, fall_evt, last_fall;

    assign half_end  = (div_cnt == div_q - 8'd1);
    assign rise_evt  = half_end && !sclk && (state == ST_ASSERT || state == ST_TRANSFER);
    assign fall_evt  = half_end && sclk && (state == ST_TRANSFER);
    assign last_fall = fall_evt && (half_cnt == LAST_HALF);

    assign cmd_pop       = (state == ST_IDLE) && !cmd_empty;
    assign rx_push       = (state == ST_DEASSERT) && !rx_full;
    assign rx_frame.data = rx_shift;
    assign busy          = (state != ST_IDLE);

    // Frame FSM and pin drivers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            cs_n     <= 1'b1;
            sclk     <= 1'b0;
            mosi     <= 1'b0;
            div_cnt  <= '0;
            half_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_pop) begin
                        cs_n     <= 1'b0;
                        mosi     <= cmd.data[W-1];  // MSB ahead of first rise
                        div_cnt  <= '0;
                        half_cnt <= '0;
                        state    <= ST_ASSERT;
                    end
                end
                ST_ASSERT, ST_TRANSFER: begin
                    if (half_end) begin
                        div_cnt  <= '0;
                        half_cnt <= half_cnt + 1'b1;
                        sclk     <= !sclk;
                        state    <= ST_TRANSFER;
                        if (last_fall) begin
                            cs_n  <= 1'b1;
                            mosi  <= 1'b0;
                            state <= ST_DEASSERT;
                        end else if (fall_evt) begin
                            mosi <= tx_shift[W-2];  // Next bit on falling edge
                        end
                    end else begin
                        div_cnt <= div_cnt + 8'd1;
                    end
                end
                ST_DEASSERT: state <= ST_IDLE;  // Frame pushed this cycle
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // Shift registers and latched divider
    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            tx_shift <= cmd.data;
            div_q    <= clk_div;
        end else if (fall_evt) begin
            tx_shift <= tx_shift << 1;
        end
        if (rise_evt)
            rx_shift <= {rx_shift[W-2:0], miso};  // Sample MISO as SCLK rises
    end

    // Set wins over a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rx_overflow <= 1'b0;
        else if (state == ST_DEASSERT && rx_full)
            rx_overflow <= 1'b1;
        else if (clear_overflow)
            rx_overflow <= 1'b0;
    end

    a_sclk_idle_low: assert property (@(posedge clk) disable iff (rst)
        cs_n |-> !sclk);

endmodule

// ==== verilog/spi_host_top.sv ====
/* AXI4-Lite SPI host with TX and RX queues and a single mode 0 chip select.
   busy covers queued frames as well as the one in flight. */
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_host_top (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp,
    output logic                sclk,
    output logic                mosi,
    input  logic                miso,
    output logic                cs_n
);
    import spi_types_pkg::*;

    spi_cmd_t    tx_data, cmd;
    spi_rx_t     rx_frame, rx_data;
    spi_status_t status;
    logic        tx_push, tx_full, tx_empty, cmd_pop;
    logic        rx_push, rx_pop, rx_full, rx_empty;
    logic        busy, rx_overflow, clear_overflow;
    logic [7:0]  clk_div;

    always_comb begin
        status.busy        = busy || !tx_empty;
        status.tx_full     = tx_full;
        status.rx_empty    = rx_empty;
        status.rx_overflow = rx_overflow;
    end

    axil_reg_decode i_decode (
        .clk(clk), .rst(rst),
        .axil_req(axil_req), .axil_rsp(axil_rsp),
        .tx_push(tx_push), .tx_data(tx_data), .tx_full(tx_full),
        .rx_pop(rx_pop), .rx_data(rx_data), .rx_empty(rx_empty),
        .status(status), .clk_div(clk_div), .clear_overflow(clear_overflow)
    );

    // Command queue
    sync_fifo #(.payload_t(spi_cmd_t), .DEPTH(`SPI_FIFO_DEPTH)) i_tx_fifo (
        .clk(clk), .rst(rst),
        .push(tx_push), .push_data(tx_data),
        .pop(cmd_pop), .pop_data(cmd),
        .full(tx_full), .empty(tx_empty)
    );

    // Receive queue
    sync_fifo #(.payload_t(spi_rx_t), .DEPTH(`SPI_FIFO_DEPTH)) i_rx_fifo (
        .clk(clk), .rst(rst),
        .push(rx_push), .push_data(rx_frame),
        .pop(rx_pop), .pop_data(rx_data),
        .full(rx_full), .empty(rx_empty)
    );

    spi_shift_engine i_engine (
        .clk(clk), .rst(rst),
        .cmd(cmd), .cmd_empty(tx_empty), .cmd_pop(cmd_pop),
        .clk_div(clk_div), .clear_overflow(clear_overflow),
        .rx_full(rx_full), .rx_push(rx_push), .rx_frame(rx_frame),
        .busy(busy), .rx_overflow(rx_overflow),
        .sclk(sclk), .mosi(mosi), .miso(miso), .cs_n(cs_n)
    );

endmodule

// ==== verification/spi_slave_model.sv ====
/* Behavioral SPI mode 0 device, MSB first. Answers each frame with the byte it got in
   the frame before, 0xA5 on the first one. */
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_slave_model (
    input  logic sclk,
    input  logic mosi,
    input  logic cs_n,
    output logic miso
);
    localparam int W = `SPI_DATA_WIDTH;

    logic [W-1:0] rx_byte   = '0;
    logic [W-1:0] tx_byte   = '0;
    logic [W-1:0] last_byte = '0;
    int           frames    = 0;

    // MSB is on MISO as soon as the device is selected
    assign miso = tx_byte[W-1] && !cs_n;

    always begin
        @(negedge cs_n);
        tx_byte = (frames == 0) ? 8'hA5 : last_byte;
        frames++;
        for (int i = 0; i < W; i++) begin
            @(posedge sclk);
            rx_byte = {rx_byte[W-2:0], mosi};  // Capture on the rising edge
            if (i < W - 1) begin
                @(negedge sclk);
                tx_byte = tx_byte << 1;        // Next bit after the fall
            end
        end
        @(posedge cs_n);
        last_byte = rx_byte;
    end

endmodule

// ==== verification/spi_host_tb.sv ====
/* Self-checking testbench for the SPI host over AXI4-Lite, with the echo slave model on
   the SPI pins. Frame checks assume the default divider is at least 2. */
`timescale 1ns/1ns
`include "spi_settings.svh"

module spi_host_tb;
    import axil_pkg::*;

    localparam int W          = `SPI_DATA_WIDTH;
    localparam int DEPTH      = `SPI_FIFO_DEPTH;
    localparam int TIMEOUT    = 100;    // Clock cycles per handshake
    localparam int IDLE_POLLS = 1000;   // STATUS reads before giving up
    localparam logic [15:0] TXDATA = 16'(`SPI_REG_TXDATA);
    localparam logic [15:0] RXDATA = 16'(`SPI_REG_RXDATA);
    localparam logic [15:0] STATUS = 16'(`SPI_REG_STATUS);
    localparam logic [15:0] CTRL   = 16'(`SPI_REG_CTRL);
    localparam int BUSY_BIT     = 3;
    localparam int TX_FULL_BIT  = 2;
    localparam int RX_EMPTY_BIT = 1;
    localparam int OVF_BIT      = 0;
    localparam int HS_AW = 0;
    localparam int HS_B  = 1;
    localparam int HS_AR = 2;
    localparam int HS_R  = 3;

    logic         clk;
    logic         rst;
    axil_req_t    req;
    axil_rsp_t    rsp;
    logic         sclk;
    logic         mosi;
    logic         miso;
    logic         cs_n;
    int           check_errors;
    int           timeouts;
    integer       seed;
    logic [W-1:0] sent[$];     // Bytes accepted through TXDATA
    logic [W-1:0] seen[$];     // Bytes observed on MOSI
    int           rx_idx;      // Frame number expected next from RXDATA
    int           high_run;
    int           last_high;   // Clock cycles of the latest SCLK high phase
    int           rise_cnt;
    logic [W-1:0] shift_in;
    logic         sclk_prev;
    logic         cs_prev;

    spi_host_top i_dut (
        .clk(clk), .rst(rst), .axil_req(req), .axil_rsp(rsp),
        .sclk(sclk), .mosi(mosi), .miso(miso), .cs_n(cs_n)
    );

    spi_slave_model i_slave (.sclk(sclk), .mosi(mosi), .cs_n(cs_n), .miso(miso));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic wait_handshake(input int which, input string what);
        int   cycles;
        logic hit;
        cycles = 0;
        hit    = 1'b0;
        while (!hit && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            case (which)
                HS_AW:   hit = rsp.awready && rsp.wready;
                HS_B:    hit = rsp.bvalid;
                HS_AR:   hit = rsp.arready;
                default: hit = rsp.rvalid;
            endcase
        end
        if (!hit) begin
            $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
            timeouts++;
        end
    endtask

    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        @(posedge clk);
        #1;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.wstrb   = 4'hF;
        wait_handshake(HS_AW, "awready and wready");
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        req.bready  = 1'b1;
        wait_handshake(HS_B, "bvalid");
        resp = rsp.bresp;
        #1 req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        #1;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        req.rready  = 1'b1;
        wait_handshake(HS_AR, "arready");
        #1 req.arvalid = 1'b0;
        wait_handshake(HS_R, "rvalid");
        data = rsp.rdata;
        resp = rsp.rresp;
        #1 req.rready = 1'b0;
    endtask

    // Poll STATUS until queued and running frames are done
    task automatic wait_idle();
        logic [31:0] word;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        word  = '1;
        while (word[BUSY_BIT] && polls < IDLE_POLLS) begin
            axil_read(STATUS, word, resp);
            polls++;
        end
        if (word[BUSY_BIT]) begin
            $display("Timeout after %0d STATUS reads waiting for busy to clear", IDLE_POLLS);
            timeouts++;
        end
    endtask

    task automatic send_random();
        logic [W-1:0] value;
        logic [1:0]   resp;
        value = W'($random(seed));
        axil_write(TXDATA, 32'(value), resp);
        check_value("txdata write resp", 32'(OKAY), 32'(resp));
        sent.push_back(value);
    endtask

    // The slave answers each frame with the byte of the frame before
    function automatic logic [W-1:0] echo_of(input int frame);
        if (frame == 0)
            return 8'hA5;
        return sent[frame - 1];
    endfunction

    task automatic expect_rx(input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(RXDATA, data, resp);
        check_value({name, " rxdata resp"}, 32'(OKAY), 32'(resp));
        check_value({name, " rxdata"}, 32'(echo_of(rx_idx)), data);
        rx_idx++;
    endtask

    // Pin monitor, samples settled values on each clock edge
    always @(posedge clk) begin
        if (rst) begin
            high_run  = 0;
            last_high = 0;
            rise_cnt  = 0;
            shift_in  = '0;
            sclk_prev = 1'b0;
            cs_prev   = 1'b1;
        end else begin
            if (sclk) begin
                high_run = high_run + 1;
            end else if (high_run != 0) begin
                last_high = high_run;
                high_run  = 0;
            end
            if (!cs_n && sclk && !sclk_prev) begin
                shift_in = {shift_in[W-2:0], mosi};  // MOSI at each rising SCLK
                rise_cnt = rise_cnt + 1;
            end
            if (cs_n && !cs_prev) begin
                check_value("sclk pulses per frame", 32'(W), 32'(rise_cnt));
                seen.push_back(shift_in);
                rise_cnt = 0;
            end
            sclk_prev = sclk;
            cs_prev   = cs_n;
        end
    end

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        req          = '0;
        rst          = 1'b1;
        seed         = 13;
        check_errors = 0;
        timeouts     = 0;
        rx_idx       = 0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        check_value("reset cs_n", 32'd1, 32'(cs_n));
        check_value("reset sclk", 32'd0, 32'(sclk));
        axil_read(STATUS, data, resp);
        check_value("reset status resp", 32'(OKAY), 32'(resp));
        check_value("reset rx_empty", 32'd1, 32'(data[RX_EMPTY_BIT]));
        check_value("reset busy", 32'd0, 32'(data[BUSY_BIT]));

        // Echo loopback at the default divider
        repeat (3) send_random();
        wait_idle();
        check_value("default sclk high time", `SPI_DEFAULT_DIV, last_high);
        repeat (3) expect_rx("loopback");

        axil_write(CTRL, 32'd2, resp);
        check_value("ctrl divider resp", 32'(OKAY), 32'(resp));
        send_random();
        wait_idle();
        check_value("divider 2 sclk high time", 32'd2, last_high);
        expect_rx("divider 2");

        axil_read(RXDATA, data, resp);
        check_value("empty rxdata resp", 32'(SLVERR), 32'(resp));
        check_value("empty rxdata data", 32'd0, data);
        axil_write(16'h0010, 32'h0, resp);  // Offset outside the map
        check_value("unknown offset resp", 32'(SLVERR), 32'(resp));

        // Slow frames so the command queue fills behind the running one
        axil_write(CTRL, 32'd8, resp);
        repeat (DEPTH + 1) send_random();
        axil_write(TXDATA, 32'h3C, resp);
        check_value("full txdata resp", 32'(SLVERR), 32'(resp));
        axil_read(STATUS, data, resp);
        check_value("tx_full while queued", 32'd1, 32'(data[TX_FULL_BIT]));

        wait_idle();
        axil_read(STATUS, data, resp);
        check_value("rx_overflow set", 32'd1, 32'(data[OVF_BIT]));
        axil_write(CTRL, 32'h100, resp);    // Also divider 0, which acts as 1
        check_value("ctrl clear resp", 32'(OKAY), 32'(resp));
        axil_read(STATUS, data, resp);
        check_value("rx_overflow cleared", 32'd0, 32'(data[OVF_BIT]));
        repeat (DEPTH) expect_rx("overflow drain");
        rx_idx++;  // That frame found the queue full
        send_random();
        wait_idle();
        check_value("divider 0 sclk high time", 32'd1, last_high);
        expect_rx("divider 0");

        check_value("frames on mosi", 32'(sent.size()), 32'(seen.size()));
        foreach (sent[i]) begin
            if (i < seen.size())
                check_value("mosi byte", 32'(sent[i]), 32'(seen[i]));
        end

        $display("Errors: %0d check failures, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== spi_host_top.f ====
+incdir+common
common/spi_types_pkg.sv
common/axil_pkg.sv
verilog/sync_fifo.sv
verilog/axil_reg_decode.sv
spi_engine/spi_shift_engine.sv
verilog/spi_host_top.sv
verification/spi_slave_model.sv
verification/spi_host_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the SPI host testbench with Verilator, exit status 1 on failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module spi_host_tb \
    -f spi_host_top.f -o spi_host_sim > build.log 2>&1 \
    && ./obj_dir/spi_host_sim > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "Regression failed" sim.log \
    && echo "Simulation finished, no failure found in sim.log" \
    || { echo "Simulation did not succeed, see build.log and sim.log"; exit 1; }
